// ==== Bender.yml ====
package:
  name: trace_sniffer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/trace_pkg.sv
      - hdl/trace_ifs.sv
      - hdl/trace_regs.sv
      - hdl/pattern_matcher.sv
      - hdl/capture_ctrl.sv
      - hdl/capture_fifo.sv
      - hdl/trigger_pulse.sv
      - hdl/trace_sniffer_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_clk_gen.sv
      - tb/trace_sniffer_assert.sv
      - tb/trace_sniffer_tb.sv

// ==== build.f ====
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_ifs.sv
hdl/trace_regs.sv
hdl/pattern_matcher.sv
hdl/capture_ctrl.sv
hdl/capture_fifo.sv
hdl/trigger_pulse.sv
hdl/trace_sniffer_top.sv
tb/tb_clk_gen.sv
tb/trace_sniffer_assert.sv
tb/trace_sniffer_tb.sv

// ==== hdl/capture_ctrl.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

module capture_ctrl (
   input  logic                          trace_clk,
   input  logic                          reset,
   input  logic                          arm,
   input  logic [`CAPTURE_LEN_BITS-1:0]  capture_len,
   input  logic                          match_valid,
   input  trace_pkg::rule_id_t           match_rule,
   capture_fifo_if.writer                fifo,
   output logic                          capturing,
   output logic                          done,
   output logic                          overflow
);

   trace_pkg::timestamp_t          timestamp;
   logic [`CAPTURE_LEN_BITS-1:0]   wr_count;         // entries taken, dropped ones included
   logic [`CAPTURE_LEN_BITS:0]     next_count;
   logic                           take;

   assign take       = capturing && match_valid;
   assign next_count = {1'b0, wr_count} + 1'b1;

   // arm empties the fifo on the same edge that starts the capture
   assign fifo.flush           = arm;
   assign fifo.wr              = take && !fifo.full;
   assign fifo.wdata.rule_id   = match_rule;
   assign fifo.wdata.timestamp = timestamp;

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         capturing <= 1'b0;
         done      <= 1'b0;
         overflow  <= 1'b0;
         timestamp <= '0;
         wr_count  <= '0;
      end else if (arm) begin
         capturing <= 1'b1;
         done      <= 1'b0;
         overflow  <= 1'b0;
         timestamp <= '0;
         wr_count  <= '0;
      end else if (capturing) begin
         timestamp <= timestamp + 1'b1;              // cycles since arm
         if (take) begin
            wr_count <= next_count[`CAPTURE_LEN_BITS-1:0];
            if (fifo.full)
               overflow <= 1'b1;                     // entry dropped
            if (next_count >= {1'b0, capture_len}) begin
               capturing <= 1'b0;
               done      <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== hdl/capture_fifo.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

module capture_fifo (
   input  logic       trace_clk,
   input  logic       reset,
   capture_fifo_if.store fifo
);

   localparam int PTR_BITS = `FIFO_LEVEL_BITS - 1;

   trace_pkg::capture_entry_t  mem [`FIFO_DEPTH];
   logic [PTR_BITS-1:0]        wr_ptr;
   logic [PTR_BITS-1:0]        rd_ptr;
   logic [`FIFO_LEVEL_BITS-1:0] level;
   logic                       do_wr;
   logic                       do_rd;

   assign fifo.full  = (level == `FIFO_DEPTH);
   assign fifo.empty = (level == '0);
   assign fifo.level = level;
   assign fifo.rdata = mem[rd_ptr];                  // head visible before the pop

   assign do_wr = fifo.wr && !fifo.full;             // write when full is dropped
   assign do_rd = fifo.rd && !fifo.empty;

   always_ff @(posedge trace_clk) begin
      if (do_wr)
         mem[wr_ptr] <= fifo.wdata;
   end

   always_ff @(posedge trace_clk) begin
      if (reset || fifo.flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

// ==== hdl/pattern_matcher.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

module pattern_matcher (
   input  logic                      trace_clk,
   input  logic                      reset,
   input  logic [`TRACE_LANES-1:0]   trace_data,
   match_cfg_if.cfg_dst              cfg,
   output logic                      match_valid,
   output trace_pkg::rule_id_t       match_rule,
   output logic                      trig_match
);

   localparam logic [`TRACE_COUNT_BITS-1:0] COUNT_MAX = '1;

   trace_pkg::trace_buf_t   window;
   trace_pkg::rule_mask_t   hit;                     // rules matching the current window
   trace_pkg::rule_id_t     first_rule;
   trace_pkg::match_count_t count_q [`TRACE_RULES];

   assign cfg.counts = count_q;

   // newest nibble enters at the bottom
   always_ff @(posedge trace_clk) begin
      if (reset)
         window <= '0;
      else
         window <= {window[`TRACE_BUF_BITS-`TRACE_LANES-1:0], trace_data};
   end

   always_comb begin
      for (int i = 0; i < `TRACE_RULES; i++) begin
         hit[i] = cfg.rule_enable[i] &&
                  ((window & cfg.mask[i]) == (cfg.pattern[i] & cfg.mask[i]));
      end
   end

   // lowest index wins
   always_comb begin
      first_rule = '0;
      for (int i = `TRACE_RULES - 1; i >= 0; i--) begin
         if (hit[i])
            first_rule = trace_pkg::rule_id_t'(i);
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         match_valid <= 1'b0;
         match_rule  <= '0;
         trig_match  <= 1'b0;
      end else begin
         match_valid <= |hit;
         match_rule  <= first_rule;
         trig_match  <= |(hit & cfg.trig_enable);
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         for (int i = 0; i < `TRACE_RULES; i++)
            count_q[i] <= '0;
      end else begin
         for (int i = 0; i < `TRACE_RULES; i++) begin
            if (cfg.clear_counts)
               count_q[i] <= '0;
            else if (hit[i] && (count_q[i] != COUNT_MAX))  // saturate at max
               count_q[i] <= count_q[i] + 1'b1;
         end
      end
   end

endmodule

// ==== hdl/trace_defs.svh ====
`ifndef TRACE_DEFS_SVH
`define TRACE_DEFS_SVH

// trace input and match window
`define TRACE_LANES       4
`define TRACE_BUF_BITS    32
`define TRACE_RULES       4
`define TRACE_COUNT_BITS  8
`define TRACE_TS_BITS     16

// capture storage
`define FIFO_DEPTH        16
`define FIFO_LEVEL_BITS   5
`define CAPTURE_LEN_BITS  8

// trigger output
`define TRIG_DELAY_BITS   8
`define TRIG_WIDTH_BITS   8

// register bus, word addressed
`define REG_ADDR_BITS     6
`define REG_DATA_BITS     32

`define REG_CTRL          6'h00  // wr: arm, clear counts; rd: status
`define REG_RULE_EN       6'h01  // rule enables, trigger enables
`define REG_CAPTURE_LEN   6'h02
`define REG_TRIG          6'h03  // delay low byte, width next byte
`define REG_FIFO_DATA     6'h04  // read pops the head entry
`define REG_PATTERN_BASE  6'h08  // one word per rule
`define REG_MASK_BASE     6'h0C
`define REG_COUNT_BASE    6'h10

`endif

// ==== hdl/trace_ifs.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

// rule configuration out to the matcher, counters back to the registers
interface match_cfg_if;
   trace_pkg::trace_buf_t   pattern [`TRACE_RULES];
   trace_pkg::trace_buf_t   mask [`TRACE_RULES];
   trace_pkg::rule_mask_t   rule_enable;
   trace_pkg::rule_mask_t   trig_enable;
   logic                    clear_counts;  // one cycle pulse
   trace_pkg::match_count_t counts [`TRACE_RULES];

   modport cfg_src (output pattern, mask, rule_enable, trig_enable, clear_counts,
                    input counts);
   modport cfg_dst (input pattern, mask, rule_enable, trig_enable, clear_counts,
                    output counts);
endinterface

interface capture_fifo_if;
   logic                          wr;
   trace_pkg::capture_entry_t     wdata;
   logic                          flush;
   logic                          rd;
   trace_pkg::capture_entry_t     rdata;  // show-ahead head
   logic                          full;
   logic                          empty;
   logic [`FIFO_LEVEL_BITS-1:0]   level;

   modport writer (output wr, wdata, flush, input full);
   modport reader (output rd, input rdata, empty, level);
   modport store  (input wr, wdata, flush, rd, output rdata, full, empty, level);
endinterface

// ==== hdl/trace_pkg.sv ====
`include "trace_defs.svh"

package trace_pkg;

   // sliding window of the most recent trace nibbles
   typedef logic [`TRACE_BUF_BITS-1:0] trace_buf_t;

   // index of one of the match rules
   typedef logic [$clog2(`TRACE_RULES)-1:0] rule_id_t;

   // one flag per rule
   typedef logic [`TRACE_RULES-1:0] rule_mask_t;

   // saturating per-rule match counter
   typedef logic [`TRACE_COUNT_BITS-1:0] match_count_t;

   // cycles since arm
   typedef logic [`TRACE_TS_BITS-1:0] timestamp_t;

   // one capture FIFO entry, rule id in the upper bits
   typedef struct packed {
      rule_id_t   rule_id;
      timestamp_t timestamp;
   } capture_entry_t;

endpackage

// ==== hdl/trace_regs.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

module trace_regs (
   input  logic                          trace_clk,
   input  logic                          reset,
   input  logic [`REG_ADDR_BITS-1:0]     reg_addr,
   input  logic [`REG_DATA_BITS-1:0]     reg_wdata,
   input  logic                          reg_write,
   input  logic                          reg_read,
   output logic [`REG_DATA_BITS-1:0]     reg_rdata,
   match_cfg_if.cfg_src                  cfg,
   capture_fifo_if.reader                fifo,
   output logic                          arm,
   output logic [`CAPTURE_LEN_BITS-1:0]  capture_len,
   output logic [`TRIG_DELAY_BITS-1:0]   trig_delay,
   output logic [`TRIG_WIDTH_BITS-1:0]   trig_width,
   input  logic                          capturing,
   input  logic                          done,
   input  logic                          overflow
);

   trace_pkg::trace_buf_t pattern_q [`TRACE_RULES];
   trace_pkg::trace_buf_t mask_q [`TRACE_RULES];
   trace_pkg::rule_mask_t rule_en_q;
   trace_pkg::rule_mask_t trig_en_q;
   logic                  clear_q;
   trace_pkg::rule_id_t   idx;                       // rule select within a group
   logic [`REG_ADDR_BITS-1:0] group;                 // address of the group's first word

   assign idx   = reg_addr[$bits(trace_pkg::rule_id_t)-1:0];
   assign group = {reg_addr[`REG_ADDR_BITS-1:2], 2'b00};

   assign cfg.pattern      = pattern_q;
   assign cfg.mask         = mask_q;
   assign cfg.rule_enable  = rule_en_q;
   assign cfg.trig_enable  = trig_en_q;
   assign cfg.clear_counts = clear_q;

   // pop goes out with the read, head is sampled on the same edge
   assign fifo.rd = reg_read && (reg_addr == `REG_FIFO_DATA);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         for (int i = 0; i < `TRACE_RULES; i++) begin
            pattern_q[i] <= '0;
            mask_q[i]    <= '0;
         end
         rule_en_q   <= '0;
         trig_en_q   <= '0;
         capture_len <= '0;
         trig_delay  <= '0;
         trig_width  <= '0;
         arm         <= 1'b0;
         clear_q     <= 1'b0;
      end else begin
         arm     <= 1'b0;                            // strobes last one cycle
         clear_q <= 1'b0;
         if (reg_write) begin
            case (reg_addr)
               `REG_CTRL: begin
                  arm     <= reg_wdata[0];
                  clear_q <= reg_wdata[1];
               end
               `REG_RULE_EN:     {trig_en_q, rule_en_q} <= reg_wdata[2*`TRACE_RULES-1:0];
               `REG_CAPTURE_LEN: capture_len <= reg_wdata[`CAPTURE_LEN_BITS-1:0];
               `REG_TRIG: begin
                  trig_delay <= reg_wdata[`TRIG_DELAY_BITS-1:0];
                  trig_width <= reg_wdata[8 +: `TRIG_WIDTH_BITS];
               end
               default: ;
            endcase
            if (group == `REG_PATTERN_BASE)
               pattern_q[idx] <= reg_wdata;
            if (group == `REG_MASK_BASE)
               mask_q[idx] <= reg_wdata;
         end
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         reg_rdata <= '0;
      end else if (reg_read) begin
         reg_rdata <= '0;
         case (reg_addr)
            `REG_CTRL:        reg_rdata[8:0] <= {fifo.level, overflow, fifo.empty, done, capturing};
            `REG_RULE_EN:     reg_rdata[2*`TRACE_RULES-1:0] <= {trig_en_q, rule_en_q};
            `REG_CAPTURE_LEN: reg_rdata[`CAPTURE_LEN_BITS-1:0] <= capture_len;
            `REG_TRIG:        reg_rdata[15:0] <= {trig_width, trig_delay};
            `REG_FIFO_DATA: begin
               if (!fifo.empty)                      // empty fifo reads as zero
                  reg_rdata[$bits(trace_pkg::capture_entry_t)-1:0] <= fifo.rdata;
            end
            default: ;
         endcase
         if (group == `REG_PATTERN_BASE)
            reg_rdata <= pattern_q[idx];
         if (group == `REG_MASK_BASE)
            reg_rdata <= mask_q[idx];
         if (group == `REG_COUNT_BASE)
            reg_rdata[`TRACE_COUNT_BITS-1:0] <= cfg.counts[idx];
      end
   end

endmodule

// ==== hdl/trace_sniffer_top.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

module trace_sniffer_top (
   input  logic                        trace_clk,
   input  logic                        reset,
   input  logic [`TRACE_LANES-1:0]     trace_data,
   input  logic [`REG_ADDR_BITS-1:0]   reg_addr,
   input  logic [`REG_DATA_BITS-1:0]   reg_wdata,
   input  logic                        reg_write,
   input  logic                        reg_read,
   output logic [`REG_DATA_BITS-1:0]   reg_rdata,
   output logic                        trace_trig_out,
   output logic                        capturing
);

   logic                                arm;
   logic [`CAPTURE_LEN_BITS-1:0]        capture_len;
   logic [`TRIG_DELAY_BITS-1:0]         trig_delay;
   logic [`TRIG_WIDTH_BITS-1:0]         trig_width;
   logic                                done;
   logic                                overflow;
   logic                                match_valid;
   logic [$clog2(`TRACE_RULES)-1:0]     match_rule;
   logic                                trig_match;

   match_cfg_if    cfg_bus ();
   capture_fifo_if fifo_bus ();

   trace_regs u_regs (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_write   (reg_write),
      .reg_read    (reg_read),
      .reg_rdata   (reg_rdata),
      .cfg         (cfg_bus.cfg_src),
      .fifo        (fifo_bus.reader),
      .arm         (arm),
      .capture_len (capture_len),
      .trig_delay  (trig_delay),
      .trig_width  (trig_width),
      .capturing   (capturing),
      .done        (done),
      .overflow    (overflow)
   );

   pattern_matcher u_matcher (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .trace_data  (trace_data),
      .cfg         (cfg_bus.cfg_dst),
      .match_valid (match_valid),
      .match_rule  (match_rule),
      .trig_match  (trig_match)
   );

   capture_ctrl u_capture (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .arm         (arm),
      .capture_len (capture_len),
      .match_valid (match_valid),
      .match_rule  (match_rule),
      .fifo        (fifo_bus.writer),
      .capturing   (capturing),
      .done        (done),
      .overflow    (overflow)
   );

   capture_fifo u_fifo (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .fifo        (fifo_bus.store)
   );

   trigger_pulse u_trigger (
      .trace_clk      (trace_clk),
      .reset          (reset),
      .trig_match     (trig_match),
      .trig_delay     (trig_delay),
      .trig_width     (trig_width),
      .trace_trig_out (trace_trig_out)
   );

endmodule

// ==== hdl/trigger_pulse.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

module trigger_pulse (
   input  logic                          trace_clk,
   input  logic                          reset,
   input  logic                          trig_match,
   input  logic [`TRIG_DELAY_BITS-1:0]   trig_delay,
   input  logic [`TRIG_WIDTH_BITS-1:0]   trig_width,
   output logic                          trace_trig_out
);

   typedef enum logic [1:0] {IDLE, DELAY, PULSE} trig_state_t;

   trig_state_t                   state;
   logic [`TRIG_DELAY_BITS-1:0]   cnt;               // shared by delay and width phases
   logic [`TRIG_WIDTH_BITS-1:0]   width_q;           // width held for the delay phase

   assign trace_trig_out = (state == PULSE);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         state   <= IDLE;
         cnt     <= '0;
         width_q <= '0;
      end else begin
         case (state)
            IDLE: begin
               width_q <= trig_width;
               if (trig_match && (trig_width != '0)) begin
                  if (trig_delay == '0) begin
                     state <= PULSE;
                     cnt   <= trig_width;
                  end else begin
                     state <= DELAY;
                     cnt   <= trig_delay;
                  end
               end
            end
            DELAY: begin
               if (cnt == 1) begin
                  state <= PULSE;
                  cnt   <= width_q;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            PULSE: begin
               if (cnt == 1)
                  state <= IDLE;
               else
                  cnt <= cnt - 1'b1;
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter real PERIOD_NS = 40.0
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD_NS / 2.0) clk = ~clk;  // free running, starts low

endmodule

// ==== tb/trace_sniffer_assert.sv ====
`timescale 1ns/1ps

module trace_sniffer_assert (
   input logic trace_clk,
   input logic reset,
   input logic fifo_wr,
   input logic fifo_full,
   input logic trace_trig_out,
   input logic capturing,
   input logic done
);

   int failures = 0;  // failed assertion count

   // capture_ctrl holds back writes once the fifo is full
   no_write_when_full: assert property (@(posedge trace_clk) disable iff (reset)
      !(fifo_wr && fifo_full))
      else begin
         failures++;
         $error("fifo write issued while the fifo is full");
      end

   trig_low_in_reset: assert property (@(posedge trace_clk) reset |=> !trace_trig_out)
      else begin
         failures++;
         $error("trigger output high while reset is asserted");
      end

   capture_state_excl: assert property (@(posedge trace_clk) disable iff (reset)
      !(capturing && done))
      else begin
         failures++;
         $error("capturing and done are both high");
      end

endmodule

bind trace_sniffer_top trace_sniffer_assert u_assert (
   .trace_clk      (trace_clk),
   .reset          (reset),
   .fifo_wr        (fifo_bus.wr),
   .fifo_full      (fifo_bus.full),
   .trace_trig_out (trace_trig_out),
   .capturing      (capturing),
   .done           (done)
);

// ==== tb/trace_sniffer_tb.sv ====
`timescale 1ns/1ps
`include "trace_defs.svh"

module trace_sniffer_tb;

   localparam int RESET_CYCLES    = 8;
   localparam int WATCHDOG_CYCLES = 20000;  // well above the length of all tests together
   localparam int POLL_LIMIT      = 100;
   localparam int COUNT_MAX       = (1 << `TRACE_COUNT_BITS) - 1;
   localparam int TS_BITS         = `TRACE_TS_BITS;
   localparam int ID_BITS         = $clog2(`TRACE_RULES);

   logic                        trace_clk;
   logic                        reset;
   logic [`TRACE_LANES-1:0]     trace_data;
   logic [`REG_ADDR_BITS-1:0]   reg_addr;
   logic [`REG_DATA_BITS-1:0]   reg_wdata;
   logic                        reg_write;
   logic                        reg_read;
   logic [`REG_DATA_BITS-1:0]   reg_rdata;
   logic                        trace_trig_out;
   logic                        capturing;

   integer seed = 32'hcd1ec6f8;
   int     errors = 0;
   int     checks = 0;

   // reference model of the window and the rules
   logic [`TRACE_BUF_BITS-1:0]  model_pattern [`TRACE_RULES];
   logic [`TRACE_BUF_BITS-1:0]  model_mask [`TRACE_RULES];
   logic [`TRACE_RULES-1:0]     model_enable = '0;
   logic [`TRACE_BUF_BITS-1:0]  model_window = '0;
   int                          model_count [`TRACE_RULES];
   bit                          model_log = 1'b0;
   int                          expected_rules [$];  // lowest matching rule per match cycle

   tb_clk_gen #(.PERIOD_NS(40.0)) u_clk (.clk(trace_clk));

   trace_sniffer_top DUT (
      .trace_clk      (trace_clk),
      .reset          (reset),
      .trace_data     (trace_data),
      .reg_addr       (reg_addr),
      .reg_wdata      (reg_wdata),
      .reg_write      (reg_write),
      .reg_read       (reg_read),
      .reg_rdata      (reg_rdata),
      .trace_trig_out (trace_trig_out),
      .capturing      (capturing)
   );

   function automatic logic [`TRACE_RULES-1:0] rule_hits(input logic [`TRACE_BUF_BITS-1:0] win);
      logic [`TRACE_RULES-1:0] hits;
      for (int i = 0; i < `TRACE_RULES; i++)
         hits[i] = model_enable[i] && ((win & model_mask[i]) == (model_pattern[i] & model_mask[i]));
      return hits;
   endfunction

   function automatic int lowest_rule(input logic [`TRACE_RULES-1:0] hits);
      int id;
      id = 0;
      for (int i = `TRACE_RULES - 1; i >= 0; i--)
         if (hits[i])
            id = i;
      return id;
   endfunction

   function automatic logic [31:0] status_word(input int level, input bit ovf, input bit empty,
                                               input bit dn, input bit capt);
      return {23'd0, 5'(level), ovf, empty, dn, capt};
   endfunction

   always @(posedge trace_clk) begin : reference_model
      logic [`TRACE_RULES-1:0] hits;
      if (reset) begin
         model_window = '0;
         for (int i = 0; i < `TRACE_RULES; i++)
            model_count[i] = 0;
      end else begin
         hits = rule_hits(model_window);  // window as it stands before this edge
         for (int i = 0; i < `TRACE_RULES; i++)
            if (hits[i] && model_count[i] < COUNT_MAX)
               model_count[i] = model_count[i] + 1;
         if (model_log && hits != '0)
            expected_rules.push_back(lowest_rule(hits));
         model_window = {model_window[`TRACE_BUF_BITS-`TRACE_LANES-1:0], trace_data};
      end
   end

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic write_reg(input logic [`REG_ADDR_BITS-1:0] addr, input logic [31:0] data);
      @(posedge trace_clk);
      reg_addr  <= addr;
      reg_wdata <= data;
      reg_write <= 1'b1;
      @(posedge trace_clk);
      reg_write <= 1'b0;
   endtask

   task automatic read_reg(input logic [`REG_ADDR_BITS-1:0] addr, output logic [31:0] data);
      @(posedge trace_clk);
      reg_addr <= addr;
      reg_read <= 1'b1;
      @(posedge trace_clk);
      reg_read <= 1'b0;
      @(negedge trace_clk);  // rdata registered on the previous edge
      data = reg_rdata;
   endtask

   task automatic drive_nibble(input logic [`TRACE_LANES-1:0] nibble);
      @(posedge trace_clk);
      trace_data <= nibble;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) drive_nibble('0);
   endtask

   task automatic drive_word(input logic [`TRACE_BUF_BITS-1:0] word);
      for (int n = `TRACE_BUF_BITS / `TRACE_LANES - 1; n >= 0; n--)
         drive_nibble(word[n*`TRACE_LANES +: `TRACE_LANES]);  // oldest nibble first
   endtask

   task automatic set_rule(input int idx, input logic [31:0] pattern, input logic [31:0] mask);
      write_reg(`REG_PATTERN_BASE + idx, pattern);
      write_reg(`REG_MASK_BASE + idx, mask);
      @(negedge trace_clk);
      model_pattern[idx] = pattern;
      model_mask[idx]    = mask;
   endtask

   task automatic set_enables(input logic [7:0] value);
      write_reg(`REG_RULE_EN, {24'd0, value});
      @(negedge trace_clk);
      model_enable = value[`TRACE_RULES-1:0];
   endtask

   task automatic wait_status(input logic [31:0] bit_mask, input string what);
      logic [31:0] data;
      int          polls;
      data  = '0;
      polls = 0;
      while ((data & bit_mask) == '0 && polls < POLL_LIMIT) begin
         read_reg(`REG_CTRL, data);
         polls++;
      end
      if ((data & bit_mask) == '0) begin
         errors++;
         $display("timeout at %0t ns: status never showed %s", $time, what);
      end
   endtask

   task automatic read_entries(input int count, input bit from_model, input int rule_id);
      logic [31:0] data;
      int          prev_ts;
      prev_ts = -1;
      for (int k = 0; k < count; k++) begin
         read_reg(`REG_FIFO_DATA, data);
         check_value($sformatf("entry %0d rule", k), data[TS_BITS +: ID_BITS],
                     from_model ? expected_rules[k] : rule_id);
         checks++;
         if (int'(data[TS_BITS-1:0]) <= prev_ts) begin
            errors++;
            $display("mismatch at %0t ns: entry %0d timestamp %0d not above %0d",
                     $time, k, data[TS_BITS-1:0], prev_ts);
         end
         prev_ts = data[TS_BITS-1:0];
      end
   endtask

   task automatic watch_trigger(input logic [31:0] word, input int delay, input int width,
                                input bit fires, input string what);
      int first_high;
      bit expect_high;
      // one edge to reach the window, one more for the registered match
      first_high = 2 + delay + 1;
      drive_word(word);
      for (int k = 1; k <= first_high + width + 4; k++) begin
         @(posedge trace_clk);
         trace_data <= '0;
         @(negedge trace_clk);
         expect_high = fires && k >= first_high && k < first_high + width;
         check_value($sformatf("%s, trigger %0d cycles after pattern", what, k),
                     trace_trig_out, expect_high);
      end
   endtask

   task automatic test_reset_and_regs();
      logic [31:0] data;
      logic [31:0] pattern;
      read_reg(`REG_CTRL, data);
      check_value("status after reset", data, status_word(0, 0, 1, 0, 0));
      check_value("trigger output after reset", trace_trig_out, 0);
      for (int i = 0; i < `TRACE_RULES; i++) begin
         pattern = 32'hC0DE_0000 + 32'h111 * (i + 1);  // never matches an all-zero window
         set_rule(i, pattern, pattern | 32'h0F00_F000);
         read_reg(`REG_PATTERN_BASE + i, data);
         check_value($sformatf("pattern %0d", i), data, pattern);
         read_reg(`REG_MASK_BASE + i, data);
         check_value($sformatf("mask %0d", i), data, pattern | 32'h0F00_F000);
      end
      set_enables(8'h5A);
      write_reg(`REG_CAPTURE_LEN, 32'h3C);
      write_reg(`REG_TRIG, 32'h0000_1F07);
      read_reg(`REG_RULE_EN, data);
      check_value("rule enable", data, 32'h5A);
      read_reg(`REG_CAPTURE_LEN, data);
      check_value("capture length", data, 32'h3C);
      read_reg(`REG_TRIG, data);
      check_value("trigger setup", data, 32'h1F07);
      set_enables(8'h00);
   endtask

   task automatic test_counters();
      logic [31:0] data;
      set_rule(0, 32'h1234_5678, 32'hFFFF_FFFF);
      set_rule(1, 32'h0000_00A5, 32'h0000_00FF);
      set_enables(8'h03);
      for (int i = 0; i < 400; i++) begin
         if (i % 40 == 0)
            drive_word(32'h1234_5678);
         else if (i % 40 == 20)
            drive_word(32'h0000_00A5);
         else
            drive_nibble($random(seed));
      end
      repeat (300) begin  // drives rule 1 into saturation
         drive_nibble(4'hA);
         drive_nibble(4'h5);
      end
      idle(10);
      for (int r = 0; r < `TRACE_RULES; r++) begin
         read_reg(`REG_COUNT_BASE + r, data);
         check_value($sformatf("count %0d", r), data, model_count[r]);
      end
      checks++;
      if (model_count[1] != COUNT_MAX) begin
         errors++;
         $display("stimulus did not bring rule 1 to saturation");
      end
      write_reg(`REG_CTRL, 32'h2);
      idle(2);
      @(negedge trace_clk);
      for (int r = 0; r < `TRACE_RULES; r++)
         model_count[r] = 0;
      for (int r = 0; r < `TRACE_RULES; r++) begin
         read_reg(`REG_COUNT_BASE + r, data);
         check_value($sformatf("count %0d after clear", r), data, 0);
      end
   endtask

   task automatic test_capture_short();
      logic [31:0] data;
      write_reg(`REG_CAPTURE_LEN, 32'd5);
      idle(10);
      expected_rules.delete();
      write_reg(`REG_CTRL, 32'h1);
      wait_status(32'h1, "capturing");
      check_value("capturing output while armed", capturing, 1);
      model_log = 1'b1;
      repeat (3) begin
         drive_word(32'h1234_5678);
         idle(3);
         drive_word(32'h0000_00A5);
         idle(3);
      end
      wait_status(32'h2, "done");
      model_log = 1'b0;
      read_reg(`REG_CTRL, data);
      check_value("status after short capture", data, status_word(5, 0, 0, 1, 0));
      check_value("capturing output after short capture", capturing, 0);
      checks++;
      if (expected_rules.size() < 5) begin
         errors++;
         $display("model saw only %0d matches during the capture", expected_rules.size());
      end
      read_entries(5, 1'b1, 0);
   endtask

   task automatic test_capture_overflow();
      logic [31:0] data;
      set_rule(2, 32'h0, 32'h0);  // empty mask matches every window
      write_reg(`REG_CAPTURE_LEN, 32'd24);
      set_enables(8'h04);
      write_reg(`REG_CTRL, 32'h1);
      wait_status(32'h1, "capturing");
      wait_status(32'h2, "done");
      read_reg(`REG_CTRL, data);
      check_value("status after long capture", data, status_word(16, 1, 0, 1, 0));
      read_entries(16, 1'b0, 2);
      read_reg(`REG_FIFO_DATA, data);
      check_value("read of empty fifo", data, 0);
      read_reg(`REG_CTRL, data);
      check_value("status after readout", data, status_word(0, 1, 1, 1, 0));
      set_enables(8'h00);
   endtask

   task automatic test_trigger();
      set_enables(8'h13);  // rules 0 and 1, trigger on rule 0 only
      write_reg(`REG_TRIG, {16'd0, 8'd4, 8'd3});
      idle(4);
      watch_trigger(32'h1234_5678, 3, 4, 1'b1, "trigger-enabled rule");
      watch_trigger(32'h0000_00A5, 3, 4, 1'b0, "rule without trigger");
      write_reg(`REG_TRIG, {16'd0, 8'd0, 8'd3});
      idle(4);
      watch_trigger(32'h1234_5678, 3, 0, 1'b1, "zero width");
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge trace_clk);
      $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      trace_data = '0;
      reg_addr   = '0;
      reg_wdata  = '0;
      reg_write  = 1'b0;
      reg_read   = 1'b0;
      reset      = 1'b1;
      repeat (RESET_CYCLES) @(posedge trace_clk);
      reset <= 1'b0;
      test_reset_and_regs();
      test_counters();
      test_capture_short();
      test_capture_overflow();
      test_trigger();
      idle(4);
      errors += DUT.u_assert.failures;
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, DUT.u_assert.failures);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule
